// File: transmit.f
hw/tx_pkg.sv
hw/tx_apb_regs.sv
hw/tx_awg.sv
hw/tx_triangle.sv
hw/tx_output_stage.sv
hw/transmit_top.sv
testbench/tb_checker.sv
testbench/tb_transmit_top.sv

// File: Bender.yml
package:
  name: transmit

sources:
  # RTL, package first
  - hw/tx_pkg.sv
  - hw/tx_apb_regs.sv
  - hw/tx_awg.sv
  - hw/tx_triangle.sv
  - hw/tx_output_stage.sv
  - hw/transmit_top.sv

  # Testbench, top module tb_transmit_top
  - target: test
    files:
      - testbench/tb_checker.sv
      - testbench/tb_transmit_top.sv

// File: testbench/tb_transmit_top.sv
////////////////////////////////////////
// Stimulus only, all comparing is done in tb_checker
// Configuration is written only while run is 0
////////////////////////////////////////
`timescale 1ns/1ps
module tb_transmit_top;

  localparam int CH = tx_pkg::CHANNELS;

  // Samples observed per run in each test
  localparam int N_TRI = 120;
  localparam int N_AWG = 96;
  localparam int N_SAT = 64;
  localparam int N_RESTART = 24;
  // APB transfers take 3 cycles, each run adds start and drain latency
  localparam int N_XFERS = 150;
  localparam int N_RUNS = 5;
  localparam int CYCLE_LIMIT = 5 + 3 * N_XFERS + N_TRI + N_AWG + N_SAT + 2 * N_RESTART +
                               10 * N_RUNS + 200;

  logic dac_clk;
  logic rst_n_i;
  logic psel;
  logic penable;
  logic pwrite;
  logic [tx_pkg::APB_ADDR_WIDTH-1:0] paddr;
  logic [tx_pkg::APB_DATA_WIDTH-1:0] pwdata;
  logic [tx_pkg::APB_DATA_WIDTH-1:0] prdata;
  logic pready;
  logic pslverr;
  logic [CH*tx_pkg::SAMPLE_WIDTH-1:0] dac_data;
  logic dac_valid;
  logic dac_trigger;
  logic test_end;
  int test_id;
  logic all_done;
  int errors;
  logic timeout;
  logic [31:0] lcg_state;

  initial begin
    dac_clk = 1'b0;
  end

  always #10 dac_clk = ~dac_clk;

  transmit_top DUT (
    .dac_clk(dac_clk), .rst_n_i(rst_n_i),
    .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
    .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
    .dac_data_o(dac_data), .dac_valid_o(dac_valid), .dac_trigger_o(dac_trigger)
  );

  tb_checker #(.CYCLE_LIMIT(CYCLE_LIMIT)) chk (
    .dac_clk(dac_clk), .rst_n_i(rst_n_i),
    .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
    .pwdata_i(pwdata), .prdata_i(prdata), .pready_i(pready), .pslverr_i(pslverr),
    .dac_data_i(dac_data), .dac_valid_i(dac_valid), .dac_trigger_i(dac_trigger),
    .test_end_i(test_end), .test_id_i(test_id), .all_done_i(all_done),
    .errors_o(errors), .timeout_o(timeout)
  );

  // Numerical Recipes constants
  function automatic logic [31:0] lcg_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [tx_pkg::APB_ADDR_WIDTH-1:0] chan_addr(input int c, input int f);
    return tx_pkg::REG_CH_BASE + 12'(16 * c + 4 * f);
  endfunction

  ////////////////////////////////////////
  // APB driver
  ////////////////////////////////////////
  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
    @(negedge dac_clk);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(negedge dac_clk);
    penable = 1'b1;
    @(negedge dac_clk);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input logic [11:0] addr);
    @(negedge dac_clk);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = addr;
    @(negedge dac_clk);
    penable = 1'b1;
    @(negedge dac_clk);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic set_channel(input int c, input logic [31:0] inc, input logic [31:0] scl,
                             input logic [31:0] ofs, input int src, input int len);
    apb_write(chan_addr(c, 0), inc);
    apb_write(chan_addr(c, 1), scl);
    apb_write(chan_addr(c, 2), ofs);
    apb_write(chan_addr(c, 3), 32'((len << tx_pkg::LEN_LSB) | src));
  endtask

  // Run until n valid samples are seen, then stop and wait for the drain
  task automatic run_for(input int n);
    int seen;
    seen = 0;
    apb_write(tx_pkg::REG_CTRL, 32'd1);
    while (seen < n) begin
      @(negedge dac_clk);
      if (dac_valid) begin
        seen++;
      end
    end
    apb_write(tx_pkg::REG_CTRL, 32'd0);
    while (dac_valid) begin
      @(negedge dac_clk);
    end
  endtask

  task automatic finish_test(input int id);
    @(negedge dac_clk);
    test_id = id;
    test_end = 1'b1;
    @(negedge dac_clk);
    test_end = 1'b0;
  endtask

  always @(posedge timeout) begin
    $display("TB FAILED");
    $finish;
  end

  initial begin
    lcg_state = 32'hf2293e87;
    rst_n_i = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    test_end = 1'b0;
    test_id = 0;
    all_done = 1'b0;
    repeat (5) @(negedge dac_clk);
    rst_n_i = 1'b1;

    // Register access, run stays 0
    apb_write(tx_pkg::REG_CTRL, lcg_rand() & ~32'd1);
    apb_read(tx_pkg::REG_CTRL);
    apb_write(tx_pkg::REG_TRIG_MASK, lcg_rand());
    apb_read(tx_pkg::REG_TRIG_MASK);
    for (int c = 0; c < CH; c++) begin
      for (int f = 0; f < 4; f++) begin
        apb_write(chan_addr(c, f), lcg_rand());
        apb_read(chan_addr(c, f));
      end
    end
    apb_read(12'h008);
    apb_write(chan_addr(CH, 0), lcg_rand());
    apb_read(12'(tx_pkg::AWG_WIN_BASE + 128 * CH));
    apb_read(12'(tx_pkg::AWG_WIN_BASE + 4));
    finish_test(1);

    // Triangle at unity gain, triangle triggers only
    for (int c = 0; c < CH; c++) begin
      set_channel(c, lcg_rand(), 32'd16384, 32'd0, tx_pkg::SRC_TRI, 0);
    end
    apb_write(tx_pkg::REG_TRIG_MASK, ((1 << CH) - 1) << CH);
    run_for(N_TRI);
    finish_test(2);

    // AWG playback with short and full length
    for (int c = 0; c < CH; c++) begin
      for (int a = 0; a < tx_pkg::AWG_DEPTH; a++) begin
        apb_write(12'(tx_pkg::AWG_WIN_BASE + 128 * c + 4 * a), lcg_rand());
      end
      set_channel(c, 32'd0, 32'd16384, 32'd0, tx_pkg::SRC_AWG, (c == 0) ? 5 : 31);
    end
    apb_write(tx_pkg::REG_TRIG_MASK, (1 << CH) - 1);
    run_for(N_AWG);
    finish_test(3);

    // Gains near +2 and -2 push the triangle past both limits
    set_channel(0, 32'h0900, 32'h7000 | (lcg_rand() & 32'h0fff), lcg_rand() & 32'h3fff,
                tx_pkg::SRC_TRI, 0);
    set_channel(1, 32'h0700, 32'h8000 | (lcg_rand() & 32'h0fff), -(lcg_rand() & 32'h3fff),
                tx_pkg::SRC_TRI, 0);
    apb_write(tx_pkg::REG_TRIG_MASK, ((1 << CH) - 1) << CH);
    run_for(N_SAT);
    finish_test(4);

    // Offset only on channel 0, restart checked through data and triggers
    set_channel(0, lcg_rand(), 32'd16384, lcg_rand(), tx_pkg::SRC_OFF, 0);
    set_channel(1, lcg_rand(), 32'd16384, 32'd0, tx_pkg::SRC_TRI, 6);
    // Channel 1 wraps only, channel 0 with length 0 would wrap every cycle
    apb_write(tx_pkg::REG_TRIG_MASK, (32'd2 << CH) | 32'd2);
    run_for(N_RESTART);
    run_for(N_RESTART);
    finish_test(5);

    @(negedge dac_clk);
    all_done = 1'b1;
    @(posedge dac_clk);
    #1;
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: testbench/tb_checker.sv
////////////////////////////////////////
// Model config is copied from APB writes seen on the bus
// Expects one APB transfer at a time, config changes only while stopped
////////////////////////////////////////
`timescale 1ns/1ps
module tb_checker #(
  parameter int CYCLE_LIMIT = 2000
) (
  input  logic dac_clk,
  input  logic rst_n_i,
  input  logic psel_i,
  input  logic penable_i,
  input  logic pwrite_i,
  input  logic [tx_pkg::APB_ADDR_WIDTH-1:0] paddr_i,
  input  logic [tx_pkg::APB_DATA_WIDTH-1:0] pwdata_i,
  input  logic [tx_pkg::APB_DATA_WIDTH-1:0] prdata_i,
  input  logic pready_i,
  input  logic pslverr_i,
  input  logic [tx_pkg::CHANNELS*tx_pkg::SAMPLE_WIDTH-1:0] dac_data_i,
  input  logic dac_valid_i,
  input  logic dac_trigger_i,
  input  logic test_end_i,
  input  int test_id_i,
  input  logic all_done_i,
  output int errors_o,
  output logic timeout_o
);

  localparam int CH = tx_pkg::CHANNELS;
  localparam int SW = tx_pkg::SAMPLE_WIDTH;

  typedef enum {A_NONE, A_CTRL, A_MASK, A_CHAN, A_WIN} addr_kind_e;

  // Copy of the configuration
  logic run;
  logic [2*CH-1:0] trig_mask;
  int tri_inc [CH];
  int scale [CH];
  int offset [CH];
  logic [1:0] src_sel [CH];
  int awg_len [CH];
  int awg_mem [CH][tx_pkg::AWG_DEPTH];

  // Source model state
  int awg_idx [CH];
  int phase [CH];
  int run_age;
  logic first_pending;

  int cycles;
  int checks;
  int test_checks;
  int test_errors;
  logic reported;

  initial begin
    errors_o = 0;
    timeout_o = 1'b0;
    cycles = 0;
    checks = 0;
    test_checks = 0;
    test_errors = 0;
    run_age = 0;
    first_pending = 1'b0;
    reported = 1'b0;
  end

  ////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////
  function automatic int tri_ref(input int ph);
    if (ph < 32768) begin
      return 2 * ph - 32768;
    end
    return 32767 - 2 * (ph - 32768);
  endfunction

  function automatic int scale_offset_ref(input int x, input int s, input int o);
    int r;
    r = ((x * s) >>> tx_pkg::SCALE_FRAC_BITS) + o;
    if (r > 32767) begin
      return 32767;
    end else if (r < -32768) begin
      return -32768;
    end
    return r;
  endfunction

  function automatic addr_kind_e addr_kind(input logic [tx_pkg::APB_ADDR_WIDTH-1:0] a);
    int ai;
    ai = int'(a);
    if (a == tx_pkg::REG_CTRL) begin
      return A_CTRL;
    end else if (a == tx_pkg::REG_TRIG_MASK) begin
      return A_MASK;
    end else if (a[1:0] != 2'b00) begin
      return A_NONE;
    end else if (ai >= tx_pkg::REG_CH_BASE && ai < tx_pkg::REG_CH_BASE + 16 * CH) begin
      return A_CHAN;
    end else if (ai >= tx_pkg::AWG_WIN_BASE && ai < tx_pkg::AWG_WIN_BASE + 128 * CH) begin
      return A_WIN;
    end
    return A_NONE;
  endfunction

  function automatic logic [31:0] read_ref(input logic [tx_pkg::APB_ADDR_WIDTH-1:0] a);
    logic [31:0] d;
    int c;
    d = '0;
    c = (int'(a) - tx_pkg::REG_CH_BASE) / 16;
    case (addr_kind(a))
      A_CTRL: d[0] = run;
      A_MASK: d[2*CH-1:0] = trig_mask;
      A_CHAN: begin
        case (a[3:0])
          4'h0: d[15:0] = tri_inc[c][15:0];
          4'h4: d[15:0] = scale[c][15:0];
          4'h8: d[15:0] = offset[c][15:0];
          default: begin
            d[1:0] = src_sel[c];
            d[12:8] = awg_len[c][4:0];
          end
        endcase
      end
      default: d = '0;
    endcase
    return d;
  endfunction

  ////////////////////////////////////////
  // Bookkeeping
  ////////////////////////////////////////
  task automatic count_check(input string sig, input longint exp_v, input longint got_v);
    checks++;
    test_checks++;
    if (exp_v != got_v) begin
      errors_o++;
      test_errors++;
      $display("ERR %0t %s expected %0d got %0d", $time, sig, exp_v, got_v);
    end
  endtask

  task automatic note_failure(input string msg);
    errors_o++;
    test_errors++;
    $display("%0t %s", $time, msg);
  endtask

  task automatic clear_config();
    run = 1'b0;
    trig_mask = '0;
    first_pending = 1'b0;
    for (int c = 0; c < CH; c++) begin
      tri_inc[c] = 0;
      scale[c] = 0;
      offset[c] = 0;
      src_sel[c] = 2'd0;
      awg_len[c] = 0;
    end
  endtask

  task automatic record_write(input logic [tx_pkg::APB_ADDR_WIDTH-1:0] a, input logic [31:0] d);
    int c;
    c = (int'(a) - tx_pkg::REG_CH_BASE) / 16;
    case (addr_kind(a))
      A_CTRL: begin
        run = d[0];
        run_age = 0;
        first_pending = d[0];
        // Starting the sources resets index and phase
        if (d[0]) begin
          for (int k = 0; k < CH; k++) begin
            awg_idx[k] = 0;
            phase[k] = 0;
          end
        end
      end
      A_MASK: trig_mask = d[2*CH-1:0];
      A_CHAN: begin
        case (a[3:0])
          4'h0: tri_inc[c] = int'(d[15:0]);
          4'h4: scale[c] = $signed(d[15:0]);
          4'h8: offset[c] = $signed(d[15:0]);
          default: begin
            src_sel[c] = d[1:0];
            awg_len[c] = int'(d[12:8]);
          end
        endcase
      end
      A_WIN: awg_mem[(int'(a) - tx_pkg::AWG_WIN_BASE) / 128][a[6:2]] = $signed(d[15:0]);
      default: ;
    endcase
  endtask

  task automatic check_apb();
    addr_kind_e kind;
    kind = addr_kind(paddr_i);
    count_check("pready_o", 1, pready_i);
    count_check("pslverr_o", (kind == A_NONE) || (kind == A_WIN && !pwrite_i), pslverr_i);
    if (pwrite_i) begin
      record_write(paddr_i, pwdata_i);
    end else if (kind != A_NONE && kind != A_WIN) begin
      count_check("prdata_o", read_ref(paddr_i), prdata_i);
    end
  endtask

  ////////////////////////////////////////
  // Sample model, one step per valid
  ////////////////////////////////////////
  task automatic check_sample();
    int sel;
    int got;
    logic exp_trig;
    exp_trig = 1'b0;
    for (int c = 0; c < CH; c++) begin
      case (src_sel[c])
        tx_pkg::SRC_AWG: sel = awg_mem[c][awg_idx[c]];
        tx_pkg::SRC_TRI: sel = tri_ref(phase[c]);
        default: sel = 0;
      endcase
      got = $signed(dac_data_i[c*SW +: SW]);
      count_check($sformatf("dac_data_o[ch%0d]", c),
                  scale_offset_ref(sel, scale[c], offset[c]), got);
      exp_trig = exp_trig | (trig_mask[c] && awg_idx[c] == 0);
      exp_trig = exp_trig | (trig_mask[CH+c] && phase[c] + tri_inc[c] > 65535);
      awg_idx[c] = (awg_idx[c] == awg_len[c]) ? 0 : awg_idx[c] + 1;
      phase[c] = (phase[c] + tri_inc[c]) % 65536;
    end
    count_check("dac_trigger_o", exp_trig, dac_trigger_i);
  endtask

  task automatic check_valid_timing();
    if (run && first_pending) begin
      if (dac_valid_i) begin
        first_pending = 1'b0;
        if (run_age != 4) begin
          note_failure($sformatf("first sample came %0d cycles after run was set, not 4",
                                 run_age));
        end
      end else if (run_age > 4) begin
        first_pending = 1'b0;
        note_failure("dac_valid_o did not rise 4 cycles after run was set");
      end
    end
    if (!run && dac_valid_i && run_age >= 4) begin
      note_failure($sformatf("dac_valid_o still high %0d cycles after run was cleared",
                             run_age));
    end
  endtask

  function automatic string test_name(input int id);
    case (id)
      1: return "register access";
      2: return "triangle source";
      3: return "AWG playback";
      4: return "scale and offset";
      5: return "source select and run";
      default: return "unknown";
    endcase
  endfunction

  always @(posedge dac_clk) begin
    cycles++;
    run_age++;
    if (cycles >= CYCLE_LIMIT && !timeout_o) begin
      $display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
      timeout_o <= 1'b1;
    end
    if (!rst_n_i) begin
      clear_config();
    end else begin
      check_valid_timing();
      if (dac_valid_i) begin
        check_sample();
      end
      if (psel_i && penable_i) begin
        check_apb();
      end
    end
    if (test_end_i) begin
      $display("Test %0d %s: %0d checks, %0d errors", test_id_i, test_name(test_id_i),
               test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
    end
    if (all_done_i && !reported) begin
      reported = 1'b1;
      $display("Total: %0d checks, %0d errors", checks, errors_o);
    end
  end

endmodule

// File: hw/transmit_top.sv
////////////////////////////////////////
// Single clock, one sample per channel per cycle
// Channel 0 in the low bits of dac_data_o
////////////////////////////////////////
`timescale 1ns/1ps
module transmit_top (
  input  logic dac_clk,
  input  logic rst_n_i,
  input  logic psel_i,
  input  logic penable_i,
  input  logic pwrite_i,
  input  logic [tx_pkg::APB_ADDR_WIDTH-1:0] paddr_i,
  input  logic [tx_pkg::APB_DATA_WIDTH-1:0] pwdata_i,
  output logic [tx_pkg::APB_DATA_WIDTH-1:0] prdata_o,
  output logic pready_o,
  output logic pslverr_o,
  output logic [tx_pkg::CHANNELS*tx_pkg::SAMPLE_WIDTH-1:0] dac_data_o,
  output logic dac_valid_o,
  output logic dac_trigger_o
);

  ////////////////////////////////////////
  // Configuration
  ////////////////////////////////////////
  logic run;
  logic [2*tx_pkg::CHANNELS-1:0] trig_mask;
  logic [tx_pkg::CHANNELS*tx_pkg::PHASE_BITS-1:0] tri_inc;
  logic [tx_pkg::CHANNELS*tx_pkg::SCALE_WIDTH-1:0] scale;
  logic [tx_pkg::CHANNELS*tx_pkg::OFFSET_WIDTH-1:0] offset;
  logic [tx_pkg::CHANNELS*tx_pkg::SRC_SEL_BITS-1:0] src_sel;
  logic [tx_pkg::CHANNELS*tx_pkg::AWG_ADDR_BITS-1:0] awg_len;
  logic awg_we;
  logic [tx_pkg::CH_BITS-1:0] awg_ch;
  logic [tx_pkg::AWG_ADDR_BITS-1:0] awg_addr;
  logic [tx_pkg::SAMPLE_WIDTH-1:0] awg_wdata;

  tx_apb_regs regs_i (
    .dac_clk, .rst_n_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .run_o(run), .trig_mask_o(trig_mask), .tri_inc_o(tri_inc), .scale_o(scale),
    .offset_o(offset), .src_sel_o(src_sel), .awg_len_o(awg_len),
    .awg_we_o(awg_we), .awg_ch_o(awg_ch), .awg_addr_o(awg_addr), .awg_wdata_o(awg_wdata)
  );

  ////////////////////////////////////////
  // Sources
  ////////////////////////////////////////
  logic [tx_pkg::CHANNELS*tx_pkg::SAMPLE_WIDTH-1:0] awg_sample;
  logic awg_valid;
  logic [tx_pkg::CHANNELS-1:0] awg_wrap;
  logic [tx_pkg::CHANNELS*tx_pkg::SAMPLE_WIDTH-1:0] tri_sample;
  logic tri_valid;
  logic [tx_pkg::CHANNELS-1:0] tri_wrap;

  tx_awg awg_i (
    .dac_clk, .rst_n_i, .run_i(run), .awg_len_i(awg_len),
    .awg_we_i(awg_we), .awg_ch_i(awg_ch), .awg_addr_i(awg_addr), .awg_wdata_i(awg_wdata),
    .awg_sample_o(awg_sample), .awg_valid_o(awg_valid), .awg_wrap_o(awg_wrap)
  );

  tx_triangle tri_i (
    .dac_clk, .rst_n_i, .run_i(run), .tri_inc_i(tri_inc),
    .tri_sample_o(tri_sample), .tri_valid_o(tri_valid), .tri_wrap_o(tri_wrap)
  );

  // Select, scale, offset and trigger merge
  tx_output_stage out_i (
    .dac_clk, .rst_n_i,
    .awg_sample_i(awg_sample), .awg_valid_i(awg_valid), .awg_wrap_i(awg_wrap),
    .tri_sample_i(tri_sample), .tri_valid_i(tri_valid), .tri_wrap_i(tri_wrap),
    .src_sel_i(src_sel), .scale_i(scale), .offset_i(offset), .trig_mask_i(trig_mask),
    .dac_data_o, .dac_valid_o, .dac_trigger_o
  );

endmodule

// File: hw/tx_output_stage.sv
////////////////////////////////////////
// Two stages, data and valid lag the sources by 2 cycles
// Scale is Q1.14 signed, 16384 is unity
////////////////////////////////////////
`timescale 1ns/1ps
module tx_output_stage (
  input  logic dac_clk,
  input  logic rst_n_i,
  input  logic [tx_pkg::CHANNELS*tx_pkg::SAMPLE_WIDTH-1:0] awg_sample_i,
  input  logic awg_valid_i,
  input  logic [tx_pkg::CHANNELS-1:0] awg_wrap_i,
  input  logic [tx_pkg::CHANNELS*tx_pkg::SAMPLE_WIDTH-1:0] tri_sample_i,
  input  logic tri_valid_i,
  input  logic [tx_pkg::CHANNELS-1:0] tri_wrap_i,
  input  logic [tx_pkg::CHANNELS*tx_pkg::SRC_SEL_BITS-1:0] src_sel_i,
  input  logic [tx_pkg::CHANNELS*tx_pkg::SCALE_WIDTH-1:0] scale_i,
  input  logic [tx_pkg::CHANNELS*tx_pkg::OFFSET_WIDTH-1:0] offset_i,
  input  logic [2*tx_pkg::CHANNELS-1:0] trig_mask_i,
  output logic [tx_pkg::CHANNELS*tx_pkg::SAMPLE_WIDTH-1:0] dac_data_o,
  output logic dac_valid_o,
  output logic dac_trigger_o
);

  logic [2*tx_pkg::CHANNELS-1:0] wraps;
  logic valid_q;
  logic trig_q;

  // Triangle wraps in the upper half, as in the mask register
  assign wraps = {tri_wrap_i, awg_wrap_i};

  ////////////////////////////////////////
  // Valid and trigger pipeline
  ////////////////////////////////////////
  always_ff @(posedge dac_clk) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      trig_q <= 1'b0;
      dac_valid_o <= 1'b0;
      dac_trigger_o <= 1'b0;
    end else begin
      valid_q <= awg_valid_i && tri_valid_i;
      trig_q <= |(wraps & trig_mask_i);
      dac_valid_o <= valid_q;
      dac_trigger_o <= trig_q;
    end
  end

  for (genvar c = 0; c < tx_pkg::CHANNELS; c++) begin : g_ch
    logic signed [tx_pkg::SAMPLE_WIDTH-1:0] sel;
    logic signed [tx_pkg::PROD_WIDTH-1:0] prod;
    logic signed [tx_pkg::SUM_WIDTH-2:0] shifted;
    logic signed [tx_pkg::SUM_WIDTH-1:0] sum;
    logic signed [tx_pkg::SAMPLE_WIDTH-1:0] data;

    always_comb begin
      case (tx_pkg::src_sel_e'(src_sel_i[c*tx_pkg::SRC_SEL_BITS +: tx_pkg::SRC_SEL_BITS]))
        tx_pkg::SRC_AWG: sel = awg_sample_i[c*tx_pkg::SAMPLE_WIDTH +: tx_pkg::SAMPLE_WIDTH];
        tx_pkg::SRC_TRI: sel = tri_sample_i[c*tx_pkg::SAMPLE_WIDTH +: tx_pkg::SAMPLE_WIDTH];
        default: sel = '0;
      endcase
    end

    // Stage 1, select and multiply
    always_ff @(posedge dac_clk) begin
      prod <= sel * $signed(scale_i[c*tx_pkg::SCALE_WIDTH +: tx_pkg::SCALE_WIDTH]);
    end

    // Arithmetic shift by dropping the fraction bits
    assign shifted = prod[tx_pkg::PROD_WIDTH-1:tx_pkg::SCALE_FRAC_BITS];
    assign sum = shifted + $signed(offset_i[c*tx_pkg::OFFSET_WIDTH +: tx_pkg::OFFSET_WIDTH]);

    // Stage 2, offset and saturate
    always_ff @(posedge dac_clk) begin
      if (sum > tx_pkg::SAMPLE_MAX) begin
        data <= tx_pkg::SAMPLE_MAX;
      end else if (sum < tx_pkg::SAMPLE_MIN) begin
        data <= tx_pkg::SAMPLE_MIN;
      end else begin
        data <= sum[tx_pkg::SAMPLE_WIDTH-1:0];
      end
    end

    assign dac_data_o[c*tx_pkg::SAMPLE_WIDTH +: tx_pkg::SAMPLE_WIDTH] = data;
  end

  // Trigger only rides on a valid sample
  a_trigger_aligned: assert property (@(posedge dac_clk) disable iff (!rst_n_i)
    dac_trigger_o |-> dac_valid_o);

endmodule

// File: hw/tx_triangle.sv
////////////////////////////////////////
// Full scale triangle, one period per phase wrap
////////////////////////////////////////
`timescale 1ns/1ps
module tx_triangle (
  input  logic dac_clk,
  input  logic rst_n_i,
  input  logic run_i,
  input  logic [tx_pkg::CHANNELS*tx_pkg::PHASE_BITS-1:0] tri_inc_i,
  output logic [tx_pkg::CHANNELS*tx_pkg::SAMPLE_WIDTH-1:0] tri_sample_o,
  output logic tri_valid_o,
  output logic [tx_pkg::CHANNELS-1:0] tri_wrap_o
);

  always_ff @(posedge dac_clk) begin
    if (!rst_n_i) begin
      tri_valid_o <= 1'b0;
    end else begin
      tri_valid_o <= run_i;
    end
  end

  for (genvar c = 0; c < tx_pkg::CHANNELS; c++) begin : g_ch
    logic [tx_pkg::PHASE_BITS-1:0] phase;
    logic [tx_pkg::PHASE_BITS:0] sum;
    logic [tx_pkg::SAMPLE_WIDTH-1:0] twice;
    logic [tx_pkg::SAMPLE_WIDTH-1:0] sample;
    logic wrap;

    // Carry out of the add marks the wrap
    assign sum = {1'b0, phase} + {1'b0, tri_inc_i[c*tx_pkg::PHASE_BITS +: tx_pkg::PHASE_BITS]};
    assign twice = {phase[tx_pkg::PHASE_BITS-2:0], 1'b0};

    always_ff @(posedge dac_clk) begin
      if (!rst_n_i || !run_i) begin
        phase <= '0;
        wrap <= 1'b0;
      end else begin
        phase <= sum[tx_pkg::PHASE_BITS-1:0];
        wrap <= sum[tx_pkg::PHASE_BITS];
      end
    end

    // Rising half then falling half, modulo 2^16
    always_ff @(posedge dac_clk) begin
      if (run_i) begin
        sample <= phase[tx_pkg::PHASE_BITS-1] ? tx_pkg::SAMPLE_MAX - twice
                                              : twice - tx_pkg::SAMPLE_MIN;
      end
    end

    assign tri_sample_o[c*tx_pkg::SAMPLE_WIDTH +: tx_pkg::SAMPLE_WIDTH] = sample;
    assign tri_wrap_o[c] = wrap;
  end

endmodule

// File: hw/tx_awg.sv
////////////////////////////////////////
// Length is last index, change it only while stopped
////////////////////////////////////////
`timescale 1ns/1ps
module tx_awg (
  input  logic dac_clk,
  input  logic rst_n_i,
  input  logic run_i,
  input  logic [tx_pkg::CHANNELS*tx_pkg::AWG_ADDR_BITS-1:0] awg_len_i,
  input  logic awg_we_i,
  input  logic [tx_pkg::CH_BITS-1:0] awg_ch_i,
  input  logic [tx_pkg::AWG_ADDR_BITS-1:0] awg_addr_i,
  input  logic [tx_pkg::SAMPLE_WIDTH-1:0] awg_wdata_i,
  output logic [tx_pkg::CHANNELS*tx_pkg::SAMPLE_WIDTH-1:0] awg_sample_o,
  output logic awg_valid_o,
  output logic [tx_pkg::CHANNELS-1:0] awg_wrap_o
);

  always_ff @(posedge dac_clk) begin
    if (!rst_n_i) begin
      awg_valid_o <= 1'b0;
    end else begin
      awg_valid_o <= run_i;
    end
  end

  for (genvar c = 0; c < tx_pkg::CHANNELS; c++) begin : g_ch
    logic [tx_pkg::SAMPLE_WIDTH-1:0] mem [tx_pkg::AWG_DEPTH];
    logic [tx_pkg::SAMPLE_WIDTH-1:0] sample;
    logic [tx_pkg::AWG_ADDR_BITS-1:0] idx;
    logic [tx_pkg::AWG_ADDR_BITS-1:0] len;
    logic wrap;

    assign len = awg_len_i[c*tx_pkg::AWG_ADDR_BITS +: tx_pkg::AWG_ADDR_BITS];

    always_ff @(posedge dac_clk) begin
      if (awg_we_i && awg_ch_i == c) begin
        mem[awg_addr_i] <= awg_wdata_i;
      end
    end

    // Playback counter, parked at 0 while stopped
    always_ff @(posedge dac_clk) begin
      if (!rst_n_i || !run_i) begin
        idx <= '0;
        wrap <= 1'b0;
      end else begin
        idx <= (idx == len) ? '0 : idx + 1'b1;
        wrap <= (idx == '0);
      end
    end

    always_ff @(posedge dac_clk) begin
      if (run_i) begin
        sample <= mem[idx];
      end
    end

    assign awg_sample_o[c*tx_pkg::SAMPLE_WIDTH +: tx_pkg::SAMPLE_WIDTH] = sample;
    assign awg_wrap_o[c] = wrap;

    a_idx_in_range: assert property (@(posedge dac_clk) disable iff (!rst_n_i)
      idx <= len);
  end

endmodule

// File: hw/tx_apb_regs.sv
////////////////////////////////////////
// No wait states, pready tied high
// Sample window writes reach the memory one cycle late
////////////////////////////////////////
`timescale 1ns/1ps
module tx_apb_regs (
  input  logic dac_clk,
  input  logic rst_n_i,
  input  logic psel_i,
  input  logic penable_i,
  input  logic pwrite_i,
  input  logic [tx_pkg::APB_ADDR_WIDTH-1:0] paddr_i,
  input  logic [tx_pkg::APB_DATA_WIDTH-1:0] pwdata_i,
  output logic [tx_pkg::APB_DATA_WIDTH-1:0] prdata_o,
  output logic pready_o,
  output logic pslverr_o,
  output logic run_o,
  output logic [2*tx_pkg::CHANNELS-1:0] trig_mask_o,
  output logic [tx_pkg::CHANNELS*tx_pkg::PHASE_BITS-1:0] tri_inc_o,
  output logic [tx_pkg::CHANNELS*tx_pkg::SCALE_WIDTH-1:0] scale_o,
  output logic [tx_pkg::CHANNELS*tx_pkg::OFFSET_WIDTH-1:0] offset_o,
  output logic [tx_pkg::CHANNELS*tx_pkg::SRC_SEL_BITS-1:0] src_sel_o,
  output logic [tx_pkg::CHANNELS*tx_pkg::AWG_ADDR_BITS-1:0] awg_len_o,
  output logic awg_we_o,
  output logic [tx_pkg::CH_BITS-1:0] awg_ch_o,
  output logic [tx_pkg::AWG_ADDR_BITS-1:0] awg_addr_o,
  output logic [tx_pkg::SAMPLE_WIDTH-1:0] awg_wdata_o
);

  tx_pkg::apb_state_e state;
  logic access;
  logic [tx_pkg::APB_ADDR_WIDTH-1:0] ch_off;
  logic [tx_pkg::APB_ADDR_WIDTH-1:0] awg_off;
  logic [tx_pkg::REG_CH_SHIFT-1:0] field;
  logic [tx_pkg::CH_BITS-1:0] reg_ch;
  logic ch_hit;
  logic awg_hit;
  logic map_hit;

  // Setup cycle arms the access cycle
  always_ff @(posedge dac_clk) begin
    if (!rst_n_i) begin
      state <= tx_pkg::APB_IDLE;
    end else if (psel_i && !penable_i) begin
      state <= tx_pkg::APB_ACCESS;
    end else begin
      state <= tx_pkg::APB_IDLE;
    end
  end

  assign access = psel_i && penable_i && (state == tx_pkg::APB_ACCESS);

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////
  assign ch_off = paddr_i - tx_pkg::REG_CH_BASE;
  assign awg_off = paddr_i - tx_pkg::AWG_WIN_BASE;
  assign field = ch_off[tx_pkg::REG_CH_SHIFT-1:0];
  assign reg_ch = ch_off[tx_pkg::REG_CH_SHIFT +: tx_pkg::CH_BITS];
  assign ch_hit = (paddr_i >= tx_pkg::REG_CH_BASE) && (paddr_i[1:0] == 2'b00) &&
                  ((ch_off >> tx_pkg::REG_CH_SHIFT) < tx_pkg::CHANNELS);
  assign awg_hit = (paddr_i >= tx_pkg::AWG_WIN_BASE) && (paddr_i[1:0] == 2'b00) &&
                   ((awg_off >> tx_pkg::AWG_WIN_SHIFT) < tx_pkg::CHANNELS);
  assign map_hit = (paddr_i == tx_pkg::REG_CTRL) || (paddr_i == tx_pkg::REG_TRIG_MASK) ||
                   ch_hit || awg_hit;

  // Read mux
  always_comb begin
    prdata_o = '0;
    if (paddr_i == tx_pkg::REG_CTRL) begin
      prdata_o[0] = run_o;
    end else if (paddr_i == tx_pkg::REG_TRIG_MASK) begin
      prdata_o[2*tx_pkg::CHANNELS-1:0] = trig_mask_o;
    end else if (ch_hit) begin
      case (field)
        tx_pkg::REG_TRI_INC:
          prdata_o[tx_pkg::PHASE_BITS-1:0] = tri_inc_o[reg_ch*tx_pkg::PHASE_BITS +: tx_pkg::PHASE_BITS];
        tx_pkg::REG_SCALE:
          prdata_o[tx_pkg::SCALE_WIDTH-1:0] = scale_o[reg_ch*tx_pkg::SCALE_WIDTH +: tx_pkg::SCALE_WIDTH];
        tx_pkg::REG_OFFSET:
          prdata_o[tx_pkg::OFFSET_WIDTH-1:0] =
            offset_o[reg_ch*tx_pkg::OFFSET_WIDTH +: tx_pkg::OFFSET_WIDTH];
        default: begin
          prdata_o[tx_pkg::SRC_SEL_BITS-1:0] =
            src_sel_o[reg_ch*tx_pkg::SRC_SEL_BITS +: tx_pkg::SRC_SEL_BITS];
          prdata_o[tx_pkg::LEN_LSB +: tx_pkg::AWG_ADDR_BITS] =
            awg_len_o[reg_ch*tx_pkg::AWG_ADDR_BITS +: tx_pkg::AWG_ADDR_BITS];
        end
      endcase
    end
  end

  assign pready_o = 1'b1;
  // Sample window is write only
  assign pslverr_o = access && (!map_hit || (awg_hit && !pwrite_i));

  ////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////
  always_ff @(posedge dac_clk) begin
    if (!rst_n_i) begin
      run_o <= 1'b0;
      trig_mask_o <= '0;
      tri_inc_o <= '0;
      scale_o <= '0;
      offset_o <= '0;
      src_sel_o <= '0;
      awg_len_o <= '0;
      awg_we_o <= 1'b0;
    end else begin
      awg_we_o <= access && pwrite_i && awg_hit;
      if (access && pwrite_i && paddr_i == tx_pkg::REG_CTRL) begin
        run_o <= pwdata_i[0];
      end
      if (access && pwrite_i && paddr_i == tx_pkg::REG_TRIG_MASK) begin
        trig_mask_o <= pwdata_i[2*tx_pkg::CHANNELS-1:0];
      end
      if (access && pwrite_i && ch_hit) begin
        case (field)
          tx_pkg::REG_TRI_INC:
            tri_inc_o[reg_ch*tx_pkg::PHASE_BITS +: tx_pkg::PHASE_BITS] <=
              pwdata_i[tx_pkg::PHASE_BITS-1:0];
          tx_pkg::REG_SCALE:
            scale_o[reg_ch*tx_pkg::SCALE_WIDTH +: tx_pkg::SCALE_WIDTH] <=
              pwdata_i[tx_pkg::SCALE_WIDTH-1:0];
          tx_pkg::REG_OFFSET:
            offset_o[reg_ch*tx_pkg::OFFSET_WIDTH +: tx_pkg::OFFSET_WIDTH] <=
              pwdata_i[tx_pkg::OFFSET_WIDTH-1:0];
          default: begin
            src_sel_o[reg_ch*tx_pkg::SRC_SEL_BITS +: tx_pkg::SRC_SEL_BITS] <=
              pwdata_i[tx_pkg::SRC_SEL_BITS-1:0];
            awg_len_o[reg_ch*tx_pkg::AWG_ADDR_BITS +: tx_pkg::AWG_ADDR_BITS] <=
              pwdata_i[tx_pkg::LEN_LSB +: tx_pkg::AWG_ADDR_BITS];
          end
        endcase
      end
    end
  end

  // Sample write payload, held for the strobe cycle
  always_ff @(posedge dac_clk) begin
    if (access && pwrite_i && awg_hit) begin
      awg_ch_o <= awg_off[tx_pkg::AWG_WIN_SHIFT +: tx_pkg::CH_BITS];
      awg_addr_o <= awg_off[2 +: tx_pkg::AWG_ADDR_BITS];
      awg_wdata_o <= pwdata_i[tx_pkg::SAMPLE_WIDTH-1:0];
    end
  end

  // Enable only ever follows a setup cycle of the same transfer
  a_penable_in_transfer: assert property (@(posedge dac_clk) disable iff (!rst_n_i)
    penable_i |-> psel_i && $past(psel_i));

endmodule

// File: hw/tx_pkg.sv
////////////////////////////////////////
// Byte addresses on APB, word aligned accesses only
// Channel blocks sit below 0x100, so at most 15 channels
// Triangle mapping needs PHASE_BITS equal to SAMPLE_WIDTH
////////////////////////////////////////
package tx_pkg;

  localparam int CHANNELS = 2;
  localparam int CH_BITS = $clog2(CHANNELS);

  // Datapath widths
  localparam int SAMPLE_WIDTH = 16;
  localparam int PHASE_BITS = 16;
  localparam int AWG_DEPTH = 32;
  localparam int AWG_ADDR_BITS = 5;
  localparam int SCALE_WIDTH = 16;
  localparam int SCALE_FRAC_BITS = 14;
  localparam int OFFSET_WIDTH = 16;
  localparam int PROD_WIDTH = SAMPLE_WIDTH + SCALE_WIDTH;
  // Shifted product plus one growth bit for the offset add
  localparam int SUM_WIDTH = PROD_WIDTH - SCALE_FRAC_BITS + 1;
  localparam logic signed [SAMPLE_WIDTH-1:0] SAMPLE_MAX = {1'b0, {(SAMPLE_WIDTH-1){1'b1}}};
  localparam logic signed [SAMPLE_WIDTH-1:0] SAMPLE_MIN = {1'b1, {(SAMPLE_WIDTH-1){1'b0}}};

  // APB bus
  localparam int APB_ADDR_WIDTH = 12;
  localparam int APB_DATA_WIDTH = 32;

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////
  localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL = 12'h000;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_TRIG_MASK = 12'h004;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_CH_BASE = 12'h010;
  // Channel block stride 0x10
  localparam int REG_CH_SHIFT = 4;
  localparam logic [REG_CH_SHIFT-1:0] REG_TRI_INC = 4'h0;
  localparam logic [REG_CH_SHIFT-1:0] REG_SCALE = 4'h4;
  localparam logic [REG_CH_SHIFT-1:0] REG_OFFSET = 4'h8;
  localparam logic [REG_CH_SHIFT-1:0] REG_SRC_LEN = 4'hc;
  localparam int LEN_LSB = 8;
  // Write-only sample window, stride 0x80 per channel
  localparam logic [APB_ADDR_WIDTH-1:0] AWG_WIN_BASE = 12'h100;
  localparam int AWG_WIN_SHIFT = 7;

  // Source select, 3 reads as off
  localparam int SRC_SEL_BITS = 2;
  typedef enum logic [SRC_SEL_BITS-1:0] {
    SRC_OFF = 2'd0,
    SRC_AWG = 2'd1,
    SRC_TRI = 2'd2
  } src_sel_e;

  typedef enum logic {
    APB_IDLE,
    APB_ACCESS
  } apb_state_e;

endpackage
